//--- verification/sdCardStimulus.txt
# C frame40(start,tx,index,arg) crcMode(0 good,1 bad crc,2 no end bit) respLen resp136 (CRC byte 00 = computed)
# W data16nibbles corruptLaneCrc token (05 good, 0B bad, 00 none)
C 4000000000 0 0 0000000000000000000000000000000000
C 48000001AA 0 48 08000001AA000000000000000000000000
C 7700000000 0 48 3700000120000000000000000000000000
C 6940FF8000 0 48 3FC1FF8080FF0000000000000000000000
C 4200000000 0 136 3F0353445352313238808BB79D66014677
C 4300000000 0 48 03AAAA0500000000000000000000000000
C 47AAAA0000 0 48 0700000700000000000000000000000000
C 4712340000 0 0 0000000000000000000000000000000000
C 77AAAA0000 0 48 3700000120000000000000000000000000
C 5700000000 0 0 0000000000000000000000000000000000
C 77AAAA0000 0 48 3700000120000000000000000000000000
C 5700000008 0 48 1700000900000000000000000000000000
C 4600000002 0 0 0000000000000000000000000000000000
C 48000001AA 1 0 0000000000000000000000000000000000
C 08000001AA 0 0 0000000000000000000000000000000000
C 48000001AA 2 0 0000000000000000000000000000000000
C 48000001AA 0 48 08000001AA000000000000000000000000
C 5900000000 0 48 1900000900000000000000000000000000
W 0123456789ABCDEF 0 05
W FEDCBA9876543210 1 0B
C 4C00000000 0 48 0C00000900000000000000000000000000
W A5A5A5A55A5A5A5A 0 00

//--- compile.f
verilog/sdCardPkg.sv
verilog/sdCmdReceiver.sv
verilog/sdCmdResponder.sv
verilog/sdCardState.sv
verilog/sdWriteReceiver.sv
verilog/sdCardTop.sv
verification/sdCardTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module sdCardTb -f compile.f -o simv &&
./obj_dir/simv > sim.log 2>&1 ||
{ echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^PASS: all tests$" sim.log && exit 0 || exit 1

//--- verification/sdCardTb.sv
`timescale 1ns/1ns

module sdCardTb;

    localparam int Nibbles    = 16;
    localparam int BusyCycles = 4;
    localparam int CyclesPerLine = 200;

    typedef struct packed {
        logic         isWrite;
        logic [63:0]  word;
        logic [7:0]   mode;
        logic [7:0]   len;
        logic [135:0] resp;
    } stimLine_t;

    logic       clk;
    logic       rst_;
    logic       cmdIn;
    logic       cmdOut;
    logic       cmdOutEn;
    logic [3:0] datIn;
    logic [3:0] datOut;
    logic       datOutEn;

    stimLine_t   lines[$];
    int          errors;
    int          checks;
    int          cycles;
    int          cycleLimit;
    logic [16:0] lfsr;

    sdCardTop #(
        .BlockNibbles (Nibbles),
        .BusyCycles   (BusyCycles)
    ) dut (
        .clk      (clk),
        .rst_     (rst_),
        .cmdIn    (cmdIn),
        .cmdOut   (cmdOut),
        .cmdOutEn (cmdOutEn),
        .datIn    (datIn),
        .datOut   (datOut),
        .datOutEn (datOutEn)
    );

    always #2 clk = ~clk;

    // Run limit scales with the number of stimulus lines
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit != 0 && cycles >= cycleLimit) begin
            $display("Timeout after %0d cycles", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ==============================
    // Reference models
    // ==============================
    // Fibonacci LFSR on x^17 + x^14 + 1
    function automatic logic [16:0] lfsrNext(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    function automatic logic [6:0] cmdCrc7(input logic [39:0] bits);
        logic [6:0] c;
        logic       fb;
        c = '0;
        for (int k = 39; k >= 0; k--) begin
            fb = bits[k] ^ c[6];
            c  = {c[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return c;
    endfunction

    // Lane i is bit i of each nibble with the first nibble in the top hex digit
    function automatic logic [15:0] laneCrc16(input logic [63:0] data, input int lane);
        logic [15:0] c;
        logic        fb;
        c = '0;
        for (int k = 0; k < 16; k++) begin
            fb = data[60 - 4 * k + lane] ^ c[15];
            c  = {c[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);
        end
        return c;
    endfunction

    // ==============================
    // Command line
    // ==============================
    task automatic sendCommand(input logic [47:0] frame);
        for (int i = 47; i >= 0; i--) begin
            @(posedge clk);
            #1 cmdIn = frame[i];
        end
        @(posedge clk);
        #1 cmdIn = 1'b1;
    endtask

    task automatic checkResponse(input int expLen, input logic [135:0] expResp);
        logic [135:0] got;
        int           n;
        int           waitCnt;
        checks++;
        if (expLen == 0) begin
            repeat (80) begin
                @(negedge clk);
                assert (!cmdOutEn) else begin
                    $display("Unexpected response on the command line");
                    errors++;
                    return;
                end
                assert (cmdOut) else begin
                    $display("CHECK FAILED cmdOut: got %h expected %h", cmdOut, 1'b1);
                    errors++;
                    return;
                end
            end
            return;
        end
        got     = '0;
        n       = 0;
        waitCnt = 0;
        @(negedge clk);
        while (!cmdOutEn && waitCnt < 20) begin
            waitCnt++;
            @(negedge clk);
        end
        assert (cmdOutEn) else begin
            $display("No response to a command that expects one");
            errors++;
            return;
        end
        while (cmdOutEn && n < 140) begin
            got[135 - n] = cmdOut;
            n++;
            @(negedge clk);
        end
        // Released command line idles high
        assert (cmdOut) else begin
            $display("CHECK FAILED cmdOut: got %h expected %h", cmdOut, 1'b1);
            errors++;
        end
        assert (n == expLen) else begin
            $display("CHECK FAILED respLen: got %h expected %h", n, expLen);
            errors++;
        end
        assert (got == expResp) else begin
            $display("CHECK FAILED cmdOut: got %h expected %h", got, expResp);
            errors++;
        end
    endtask

    // ==============================
    // Data lanes
    // ==============================
    task automatic sendBlock(input logic [63:0] data, input logic corrupt);
        logic [3:0][15:0] crcs;
        for (int i = 0; i < 4; i++) begin
            crcs[i] = laneCrc16(data, i);
        end
        if (corrupt) begin
            crcs[2][0] = ~crcs[2][0];
        end
        @(posedge clk);
        #1 datIn = 4'h0;
        for (int k = 0; k < 16; k++) begin
            @(posedge clk);
            #1 datIn = data[63 - 4 * k -: 4];
        end
        for (int k = 15; k >= 0; k--) begin
            @(posedge clk);
            #1 datIn = {crcs[3][k], crcs[2][k], crcs[1][k], crcs[0][k]};
        end
        @(posedge clk);
        #1 datIn = 4'hF;
    endtask

    task automatic checkToken(input logic [4:0] expTok);
        logic [4:0] seq;
        int         waitCnt;
        checks++;
        if (expTok == 5'h00) begin
            repeat (80) begin
                @(negedge clk);
                assert (!datOutEn) else begin
                    $display("Unexpected CRC token on the data lines");
                    errors++;
                    return;
                end
                assert (datOut == 4'hF) else begin
                    $display("CHECK FAILED datOut: got %h expected %h", datOut, 4'hF);
                    errors++;
                    return;
                end
            end
            return;
        end
        waitCnt = 0;
        @(negedge clk);
        while (!datOutEn && waitCnt < 20) begin
            waitCnt++;
            @(negedge clk);
        end
        assert (datOutEn) else begin
            $display("No CRC status token after a write block");
            errors++;
            return;
        end
        // Token, busy zeros, then one release cycle
        for (int i = 0; i < 5 + BusyCycles + 1; i++) begin
            if (i < 5) begin
                seq = expTok;
                assert (datOut == {3'b000, seq[4 - i]}) else begin
                    $display("CHECK FAILED datOut: got %h expected %h", datOut, seq[4 - i]);
                    errors++;
                end
            end else begin
                assert (datOutEn && datOut == {3'b000, i == 5 + BusyCycles})
                else begin
                    $display("CHECK FAILED datOut: got %h expected %h", datOut,
                             i == 5 + BusyCycles);
                    errors++;
                end
            end
            @(negedge clk);
        end
        assert (!datOutEn) else begin
            $display("CHECK FAILED datOutEn: got %h expected %h", datOutEn, 1'b0);
            errors++;
        end
        // Released data lanes idle high
        assert (datOut == 4'hF) else begin
            $display("CHECK FAILED datOut: got %h expected %h", datOut, 4'hF);
            errors++;
        end
    endtask

    // ==============================
    // Stimulus file
    // ==============================
    task automatic loadStimulus();
        int           fd;
        int           m;
        int           l;
        string        line;
        logic [63:0]  w;
        logic [135:0] r;
        stimLine_t    s;
        fd = $fopen("verification/sdCardStimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            s = '0;
            if (line.len() > 0 && line[0] == "C") begin
                void'($sscanf(line, "C %h %d %d %h", w, m, l, r));
                s.word = w;
                s.mode = 8'(m);
                s.len  = 8'(l);
                s.resp = r;
                lines.push_back(s);
            end else if (line.len() > 0 && line[0] == "W") begin
                void'($sscanf(line, "W %h %d %h", w, m, r));
                s.isWrite = 1'b1;
                s.word    = w;
                s.mode    = 8'(m);
                s.resp    = r;
                lines.push_back(s);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        stimLine_t    s;
        logic [47:0]  frame;
        logic [135:0] exp;
        int           gap;
        clk        = 1'b0;
        rst_       = 1'b0;
        cmdIn      = 1'b1;
        datIn      = 4'hF;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        cycleLimit = 0;
        lfsr       = 17'd84275;
        loadStimulus();
        cycleLimit = CyclesPerLine * (lines.size() + 1);
        repeat (10) @(posedge clk);
        #1 rst_ = 1'b1;
        foreach (lines[i]) begin
            s = lines[i];
            if (s.isWrite) begin
                sendBlock(s.word, s.mode[0]);
                checkToken(s.resp[4:0]);
            end else begin
                gap = 0;
                for (int b = 0; b < 3; b++) begin
                    lfsr = lfsrNext(lfsr);
                    gap  = gap * 2 + int'(lfsr[0]);
                end
                repeat (gap) @(posedge clk);
                frame = {s.word[39:0], cmdCrc7(s.word[39:0]), 1'b1};
                if (s.mode == 8'd1) frame[7:1] = frame[7:1] ^ 7'h01;
                if (s.mode == 8'd2) frame[0] = 1'b0;
                exp = s.resp;
                // Zero CRC byte in a short response means CRC7 plus end bit
                if (s.len == 8'd48 && exp[95:88] == 8'h00) begin
                    exp[95:88] = {cmdCrc7(exp[135:96]), 1'b1};
                end
                sendCommand(frame);
                checkResponse(int'(s.len), exp);
            end
        end
        $display("Stimulus lines: %0d, checks: %0d, errors: %0d",
                 lines.size(), checks, errors);
        if (errors == 0 && lines.size() > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- verilog/sdCardTop.sv
`timescale 1ns/1ns

module sdCardTop import sdCardPkg::*; #(
    parameter int BlockNibbles = 1024,
    parameter int NcrCycles    = 2,
    parameter int NcrcCycles   = 2,
    parameter int BusyCycles   = 4
) (
    input  logic       clk,
    input  logic       rst_,
    input  logic       cmdIn,
    output logic       cmdOut,
    output logic       cmdOutEn,
    input  logic [3:0] datIn,
    output logic [3:0] datOut,
    output logic       datOutEn
);
    sdCmdFrame_t   frame;
    logic          frameValid;
    sdCardEvent_t  cardEvent;
    logic          eventValid;
    sdCardStatus_t status;

    sdCmdReceiver cmdReceiver (
        .clk        (clk),
        .rst_       (rst_),
        .cmdIn      (cmdIn),
        .frame      (frame),
        .frameValid (frameValid)
    );

    sdCmdResponder #(
        .NcrCycles (NcrCycles)
    ) cmdResponder (
        .clk        (clk),
        .rst_       (rst_),
        .frame      (frame),
        .frameValid (frameValid),
        .status     (status),
        .cmdOut     (cmdOut),
        .cmdOutEn   (cmdOutEn),
        .cardEvent  (cardEvent),
        .eventValid (eventValid)
    );

    sdCardState cardState (
        .clk        (clk),
        .rst_       (rst_),
        .cardEvent  (cardEvent),
        .eventValid (eventValid),
        .status     (status)
    );

    // Data lanes only listen while write mode is set
    sdWriteReceiver #(
        .BlockNibbles (BlockNibbles),
        .NcrcCycles   (NcrcCycles),
        .BusyCycles   (BusyCycles)
    ) writeReceiver (
        .clk      (clk),
        .rst_     (rst_),
        .datIn    (datIn),
        .status   (status),
        .datOut   (datOut),
        .datOutEn (datOutEn)
    );

endmodule

//--- verilog/sdWriteReceiver.sv
`timescale 1ns/1ns

module sdWriteReceiver import sdCardPkg::*; #(
    parameter int BlockNibbles = 1024,
    parameter int NcrcCycles   = 2,
    parameter int BusyCycles   = 4
) (
    input  logic          clk,
    input  logic          rst_,
    input  logic [3:0]    datIn,
    input  sdCardStatus_t status,
    output logic [3:0]    datOut,
    output logic          datOutEn
);
    // CRC status tokens on DAT0, sent MSB first
    localparam logic [4:0] TokenGood = 5'b00101;
    localparam logic [4:0] TokenBad  = 5'b01011;

    typedef enum logic [2:0] {
        WrWaitStart,
        WrData,
        WrCrc,
        WrEndBit,
        WrGap,
        WrToken,
        WrBusy,
        WrRelease
    } wrState_e;

    wrState_e         state;
    logic [15:0]      cnt;
    logic [3:0][15:0] ourCrc;
    logic [3:0][15:0] theirCrc;
    logic             tokenGood;
    logic [4:0]       tokenWord;
    logic             abort;

    // Stop before the token drops the block silently
    assign abort     = !status.writeActive &&
                       (state inside {WrData, WrCrc, WrEndBit, WrGap});
    assign tokenWord = tokenGood ? TokenGood : TokenBad;

    // ==============================
    // Block FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            state <= WrWaitStart;
            cnt   <= '0;
        end else if (abort) begin
            state <= WrWaitStart;
            cnt   <= '0;
        end else begin
            cnt <= cnt + 1'b1;
            case (state)
                WrWaitStart: begin
                    cnt <= '0;
                    if (status.writeActive && !datIn[0]) begin
                        state <= WrData;
                    end
                end
                WrData: begin
                    if (cnt == 16'(BlockNibbles - 1)) begin
                        state <= WrCrc;
                        cnt   <= '0;
                    end
                end
                WrCrc: begin
                    if (cnt == 16'd15) begin
                        state <= WrEndBit;
                        cnt   <= '0;
                    end
                end
                WrEndBit: begin
                    state <= WrGap;
                    cnt   <= '0;
                end
                WrGap: begin
                    // At least one idle cycle before the token
                    if (cnt == 16'(NcrcCycles - 1)) begin
                        state <= WrToken;
                        cnt   <= '0;
                    end
                end
                WrToken: begin
                    if (cnt == 16'd4) begin
                        state <= WrBusy;
                        cnt   <= '0;
                    end
                end
                WrBusy: begin
                    if (cnt == 16'(BusyCycles - 1)) begin
                        state <= WrRelease;
                        cnt   <= '0;
                    end
                end
                WrRelease: begin
                    state <= WrWaitStart;
                    cnt   <= '0;
                end
                default: state <= WrWaitStart;
            endcase
        end
    end

    // ==============================
    // Lane CRCs and token choice
    // ==============================
    always_ff @(posedge clk) begin
        case (state)
            WrWaitStart: ourCrc <= '0;
            WrData: begin
                for (int i = 0; i < 4; i++) begin
                    ourCrc[i] <= crc16Step(ourCrc[i], datIn[i]);
                end
            end
            WrCrc: begin
                for (int i = 0; i < 4; i++) begin
                    theirCrc[i] <= {theirCrc[i][14:0], datIn[i]};
                end
            end
            // All four lanes need a good CRC and a high end bit
            WrEndBit: tokenGood <= (ourCrc == theirCrc) && (&datIn);
            default: ;
        endcase
    end

    always_comb begin
        datOutEn = 1'b1;
        datOut   = 4'b0000;
        case (state)
            WrToken:   datOut[0] = tokenWord[3'd4 - cnt[2:0]];
            WrBusy:    datOut[0] = 1'b0;
            WrRelease: datOut[0] = 1'b1;
            default: begin
                datOutEn = 1'b0;
                datOut   = 4'b1111;
            end
        endcase
    end

endmodule

//--- verilog/sdCardState.sv
`timescale 1ns/1ns

module sdCardState import sdCardPkg::*; (
    input  logic          clk,
    input  logic          rst_,
    input  sdCardEvent_t  cardEvent,
    input  logic          eventValid,
    output sdCardStatus_t status
);

    // Conditions are decided by the responder, events apply as given
    always_ff @(posedge clk) begin
        if (!rst_) begin
            status <= '0;
        end else if (eventValid) begin
            // Prefix lasts for exactly one command
            status.appCmd <= cardEvent.appNext;
            if (cardEvent.goIdle) begin
                status.rca         <= '0;
                status.writeActive <= 1'b0;
                status.appCmd      <= 1'b0;
            end else begin
                if (cardEvent.assignRca) begin
                    status.rca <= NewRca;
                end
                if (cardEvent.startWrite) begin
                    status.writeActive <= 1'b1;
                end
                if (cardEvent.stopWrite) begin
                    status.writeActive <= 1'b0;
                end
            end
        end
    end

endmodule

//--- verilog/sdCmdResponder.sv
`timescale 1ns/1ns

module sdCmdResponder import sdCardPkg::*; #(
    parameter int NcrCycles = 2
) (
    input  logic          clk,
    input  logic          rst_,
    input  sdCmdFrame_t   frame,
    input  logic          frameValid,
    input  sdCardStatus_t status,
    output logic          cmdOut,
    output logic          cmdOutEn,
    output sdCardEvent_t  cardEvent,
    output logic          eventValid
);
    // CRC7 field position inside a 48-bit response
    localparam int CrcFirst = R1Bits - 8;
    localparam int CrcLast  = R1Bits - 2;

    typedef enum logic [1:0] {
        RespIdle,
        RespWait,
        RespSend
    } respState_e;

    respState_e        state;
    sdCmd_e            cmd;
    logic              decResp;
    logic              decCrc;
    logic              decLong;
    logic [7:0]        decHeader;
    logic [31:0]       decContent;
    sdCardEvent_t      decEvent;
    logic [R2Bits-1:0] respShift;
    logic [6:0]        crc;
    logic              useCrc;
    logic [7:0]        respLen;
    logic [7:0]        bitCnt;
    logic [7:0]        waitCnt;
    logic              accept;
    logic              emit;
    logic              crcPhase;
    logic              outBit;

    assign cmd    = sdCmd_e'({status.appCmd, frame.index});
    // Frames during a pending response are dropped
    assign accept = frameValid && (state == RespIdle);

    assign crcPhase = useCrc && (bitCnt >= 8'(CrcFirst)) && (bitCnt <= 8'(CrcLast));
    assign outBit   = crcPhase ? crc[6] : respShift[R2Bits-1];
    // NcrCycles of at least one idle cycle
    assign emit     = ((state == RespWait) && (waitCnt == 8'(NcrCycles - 1))) ||
                      ((state == RespSend) && (bitCnt != respLen));

    // ==============================
    // Command decode
    // ==============================
    always_comb begin
        decResp    = 1'b1;
        decCrc     = 1'b1;
        decLong    = 1'b0;
        decHeader  = {2'b00, frame.index};
        decContent = StatusTransfer;
        decEvent   = '0;
        case (cmd)
            Cmd0: begin
                decResp         = 1'b0;
                decEvent.goIdle = 1'b1;
            end
            Cmd2: decLong = 1'b1;
            Cmd3: begin
                // R6 carries the new RCA and the low status bits
                decContent         = {NewRca, StatusIdent[15:0]};
                decEvent.assignRca = 1'b1;
            end
            Cmd7: begin
                decResp    = (frame.arg.rcaView.rca == status.rca);
                decContent = StatusStandby;
            end
            Cmd8:  decContent = {20'h0, frame.arg.rcaView.stuff[11:0]};
            Cmd12: decEvent.stopWrite = 1'b1;
            Cmd25: decEvent.startWrite = 1'b1;
            Cmd55: begin
                decContent       = StatusApp;
                decEvent.appNext = 1'b1;
            end
            Acmd6:  decContent = StatusTransfer;
            Acmd23: decResp = (frame.arg.countView.blockCount != '0);
            Acmd41: begin
                // R3 has no CRC, field sent as all ones
                decCrc     = 1'b0;
                decHeader  = 8'h3F;
                decContent = OcrReady;
            end
            default: decResp = 1'b0;
        endcase
    end

    // ==============================
    // Response sequencing
    // ==============================
    always_ff @(posedge clk) begin
        if (!rst_) begin
            state      <= RespIdle;
            waitCnt    <= '0;
            bitCnt     <= '0;
            cmdOut     <= 1'b1;
            cmdOutEn   <= 1'b0;
            eventValid <= 1'b0;
        end else begin
            eventValid <= 1'b0;
            case (state)
                RespIdle: begin
                    if (accept) begin
                        if (decResp) begin
                            state   <= RespWait;
                            waitCnt <= '0;
                            bitCnt  <= '0;
                        end else begin
                            // No response, state changes right away
                            eventValid <= 1'b1;
                        end
                    end
                end
                RespWait: begin
                    waitCnt <= waitCnt + 1'b1;
                    if (emit) begin
                        state <= RespSend;
                    end
                end
                RespSend: begin
                    if (!emit) begin
                        state      <= RespIdle;
                        cmdOut     <= 1'b1;
                        cmdOutEn   <= 1'b0;
                        eventValid <= 1'b1;
                    end
                end
                default: state <= RespIdle;
            endcase
            if (emit) begin
                cmdOut   <= outBit;
                cmdOutEn <= 1'b1;
                bitCnt   <= bitCnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            if (decLong) begin
                respShift <= {8'h3F, CardCid};
                respLen   <= 8'(R2Bits);
            end else begin
                respShift <= {decHeader, decContent, decCrc ? 7'h00 : 7'h7F, 1'b1,
                              {(R2Bits - R1Bits){1'b0}}};
                respLen   <= 8'(R1Bits);
            end
            crc       <= '0;
            useCrc    <= decCrc && !decLong;
            // Held until eventValid fires
            cardEvent <= decEvent;
        end
        if (emit) begin
            respShift <= respShift << 1;
            if (bitCnt < 8'(CrcFirst)) begin
                crc <= crc7Step(crc, respShift[R2Bits-1]);
            end else begin
                crc <= crc << 1;
            end
        end
    end

endmodule

//--- verilog/sdCmdReceiver.sv
`timescale 1ns/1ns

module sdCmdReceiver import sdCardPkg::*; (
    input  logic        clk,
    input  logic        rst_,
    input  logic        cmdIn,
    output sdCmdFrame_t frame,
    output logic        frameValid
);
    // Start, transmission, index and argument are covered by the CRC
    localparam int CrcBits = CmdFrameBits - 8;

    logic                    busy;
    logic [5:0]              bitCnt;
    logic [CmdFrameBits-3:0] shiftReg;
    logic [6:0]              crc;
    logic                    lastBit;
    logic                    frameOk;

    // bitCnt counts bits after the start bit, so the end bit arrives at 46
    assign lastBit = busy && (bitCnt == 6'(CmdFrameBits - 2));

    // Transmission bit, CRC field and end bit still on the line
    assign frameOk = shiftReg[CmdFrameBits-3] && (shiftReg[6:0] == crc) && cmdIn;

    always_ff @(posedge clk) begin
        if (!rst_) begin
            busy       <= 1'b0;
            bitCnt     <= '0;
            frameValid <= 1'b0;
        end else begin
            frameValid <= lastBit && frameOk;
            if (!busy) begin
                // Zero on an idle line is the start bit
                busy   <= !cmdIn;
                bitCnt <= '0;
            end else begin
                bitCnt <= bitCnt + 1'b1;
                if (lastBit) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            crc <= '0;
        end else begin
            shiftReg <= {shiftReg[CmdFrameBits-4:0], cmdIn};
            // Start bit is zero and leaves a zero CRC unchanged
            if (bitCnt < 6'(CrcBits - 1)) begin
                crc <= crc7Step(crc, cmdIn);
            end
        end
        if (lastBit) begin
            frame.index <= shiftReg[44:39];
            frame.arg   <= shiftReg[38:7];
        end
    end

endmodule

//--- verilog/sdCardPkg.sv
package sdCardPkg;

    // ==============================
    // Command encoding
    // ==============================
    typedef logic [5:0]  sdCmdIndex_t;
    typedef logic [15:0] sdRca_t;

    // Application flag in the top bit, index below
    typedef enum logic [6:0] {
        Cmd0   = {1'b0, 6'd0},
        Cmd2   = {1'b0, 6'd2},
        Cmd3   = {1'b0, 6'd3},
        Cmd7   = {1'b0, 6'd7},
        Cmd8   = {1'b0, 6'd8},
        Cmd12  = {1'b0, 6'd12},
        Cmd25  = {1'b0, 6'd25},
        Cmd55  = {1'b0, 6'd55},
        Acmd6  = {1'b1, 6'd6},
        Acmd23 = {1'b1, 6'd23},
        Acmd41 = {1'b1, 6'd41}
    } sdCmd_e;

    // Argument as seen by CMD7 and CMD55
    typedef struct packed {
        sdRca_t      rca;
        logic [15:0] stuff;
    } sdRcaArg_t;

    // Argument as seen by ACMD23
    typedef struct packed {
        logic [8:0]  reserved;
        logic [22:0] blockCount;
    } sdCountArg_t;

    typedef union packed {
        sdRcaArg_t   rcaView;
        sdCountArg_t countView;
    } sdArg_u;

    typedef struct packed {
        sdCmdIndex_t index;
        sdArg_u      arg;
    } sdCmdFrame_t;

    // Requests from the responder to the card state
    typedef struct packed {
        logic goIdle;
        logic assignRca;
        logic appNext;
        logic startWrite;
        logic stopWrite;
    } sdCardEvent_t;

    typedef struct packed {
        sdRca_t rca;
        logic   appCmd;
        logic   writeActive;
    } sdCardStatus_t;

    // ==============================
    // Response constants
    // ==============================
    localparam sdRca_t NewRca = 16'hAAAA;

    // CID with its own CRC7 and end bit in the low byte
    localparam logic [127:0] CardCid = 128'h0353_4453_5231_3238_808b_b79d_6601_4677;

    localparam logic [31:0] StatusIdent    = 32'h0000_0500;
    localparam logic [31:0] StatusStandby  = 32'h0000_0700;
    localparam logic [31:0] StatusTransfer = 32'h0000_0900;
    localparam logic [31:0] StatusApp      = 32'h0000_0120;
    localparam logic [31:0] OcrReady       = 32'hC1FF_8080;

    localparam int CmdFrameBits = 48;
    localparam int R1Bits       = 48;
    localparam int R2Bits       = 136;

    // ==============================
    // CRC steps
    // ==============================
    // x^7 + x^3 + 1
    function automatic logic [6:0] crc7Step(input logic [6:0] crc, input logic din);
        logic fb;
        fb = din ^ crc[6];
        return {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    endfunction

    // x^16 + x^12 + x^5 + 1
    function automatic logic [15:0] crc16Step(input logic [15:0] crc, input logic din);
        logic fb;
        fb = din ^ crc[15];
        return {crc[14:12], crc[11] ^ fb, crc[10:5], crc[4] ^ fb, crc[3:0], fb};
    endfunction

endpackage
